//--- Bender.yml
package:
  name: vec_ialu

sources:
  - include_dirs:
      - logic
    files:
      - logic/ialu_pkg.sv
      - logic/ialu_decode.sv
      - logic/ialu_execute.sv
      - logic/ialu_result.sv
      - logic/vec_ialu.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/vec_ialu_props.sv
      - bench/vec_ialu_tb.sv

//--- bench/vec_ialu_props.sv
// --------------------------------------------------
// Vector ALU interface assertions
// Result credits, request contents and multiply stall
// --------------------------------------------------

`include "ialu_defs.svh"

module vec_ialu_props (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  ialu_pkg::ialu_req_s in_req,
    input  logic                res_valid,
    input  logic                res_credit,
    input  logic                uop_valid,
    input  logic                uop_ready,
    input  logic                uop_iter
);

    localparam int CRED_W = $clog2(`IALU_RES_CREDITS + 1) + 1;

    logic [CRED_W-1:0] port_credits;           // Consumer slots seen at the ports

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            port_credits <= CRED_W'(`IALU_RES_CREDITS);
        end else begin
            port_credits <= port_credits - CRED_W'(res_valid) + CRED_W'(res_credit);
        end
    end

    // A result leaves only against a held credit
    a_res_credit : assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (port_credits != '0))
        else $error("res_valid high with the result credit count at zero");

    a_req_known : assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(in_req))
        else $error("in_req carries unknown bits while in_valid is high");

    // Accepted multiply blocks the next uop for every step
    a_mul_stall : assert property (@(posedge clk) disable iff (!rst_n)
        (uop_valid && uop_ready && uop_iter) |=> (!uop_ready) [*`IALU_XLEN])
        else $error("uop_ready rose during a multiply iteration");

endmodule

//--- bench/vec_ialu_tb.sv
// --------------------------------------------------
// Vector integer ALU testbench
// Random credited commands checked per lane against
// a reference model
// --------------------------------------------------

`include "ialu_defs.svh"

module vec_ialu_tb;
    import ialu_pkg::*;

    localparam int XLEN    = `IALU_XLEN;
    localparam int TIMEOUT = 1000;             // Cycles allowed per wait

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    ialu_req_s  in_req;
    logic       in_credit;
    logic       res_valid;
    ialu_res_s  res;
    logic       res_credit;

    ialu_res_s  exp_q[$];                      // Model results in command order
    int         cmd_credits;
    int         owed_credits;                  // Results not yet credited back
    int         valid_cnt;
    int         credit_cnt;
    bit         hold_credits;
    int         error_count;
    int         tests_run;
    int         tests_failed;

    vec_ialu u_vec_ialu (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

    bind vec_ialu vec_ialu_props u_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .res_valid  (res_valid),
        .res_credit (res_credit),
        .uop_valid  (uop_valid),
        .uop_ready  (uop_ready),
        .uop_iter   (uop.iter)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    //--------------------------------------------------
    // Reference model
    //--------------------------------------------------
    function automatic void model_lane(input ialu_cmd_e cmd, input lane_word_t a,
                                       input lane_word_t b, output lane_word_t w,
                                       output logic c);
        logic [2*XLEN-1:0] prod;
        logic [4:0]        sh;
        sh   = b[4:0];
        c    = 1'b0;
        w    = '0;
        prod = '0;
        case (cmd)
            CMD_AND    : w = a & b;
            CMD_OR     : w = a | b;
            CMD_XOR    : w = a ^ b;
            CMD_ADD    : w = a + b;
            CMD_SUB    : w = a - b;
            CMD_LT     : c = $signed(a) < $signed(b);
            CMD_LTU    : c = a < b;
            CMD_EQ     : c = a == b;
            CMD_NE     : c = a != b;
            CMD_GE     : c = $signed(a) >= $signed(b);
            CMD_GEU    : c = a >= b;
            CMD_SLL    : w = a << sh;
            CMD_SRL    : w = a >> sh;
            CMD_SRA    : w = $signed(a) >>> sh;
            CMD_MUL, CMD_MULH : prod = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{b[XLEN-1]}}, b};
            CMD_MULHSU : prod = {{XLEN{a[XLEN-1]}}, a} * {{XLEN{1'b0}}, b};
            CMD_MULHU  : prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
            default    : w = '0;
        endcase
        if (cmd inside {CMD_LT, CMD_LTU, CMD_EQ, CMD_NE, CMD_GE, CMD_GEU}) begin
            w = lane_word_t'(c);
        end else if (cmd == CMD_MUL) begin
            w = prod[XLEN-1:0];
        end else if (cmd inside {CMD_MULH, CMD_MULHSU, CMD_MULHU}) begin
            w = prod[2*XLEN-1:XLEN];
        end
    endfunction

    function automatic ialu_res_s model_result(input ialu_req_s req);
        ialu_res_s  r;
        lane_word_t w;
        logic       c;
        for (int i = 0; i < `IALU_LANES; i++) begin
            model_lane(req.cmd, req.op1[i], req.op2[i], w, c);
            r.data[i] = w;
            r.cmp[i]  = c;
        end
        return r;
    endfunction

    // Corner values come up often
    function automatic lane_word_t rand_word();
        case ($urandom_range(7, 0))
            0       : return '0;
            1       : return '1;
            2       : return lane_word_t'(1) << (XLEN - 1);
            3       : return ~(lane_word_t'(1) << (XLEN - 1));
            4       : return lane_word_t'($urandom_range(XLEN + 2, 0));
            default : return lane_word_t'($urandom);
        endcase
    endfunction

    //--------------------------------------------------
    // Compare tasks
    //--------------------------------------------------
    task automatic check_res(input string name, input lane_vec_t exp_v, input lane_vec_t act_v);
        for (int i = 0; i < `IALU_LANES; i++) begin
            if (act_v[i] !== exp_v[i]) begin
                $display("[ERROR] %0t %s[%0d] expected %h actual %h",
                         $time, name, i, exp_v[i], act_v[i]);
                error_count++;
            end
        end
    endtask

    task automatic check_cmp(input string name, input logic [`IALU_LANES-1:0] exp_m,
                             input logic [`IALU_LANES-1:0] act_m);
        if (act_m !== exp_m) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp_m, act_m);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_b, input logic act_b);
        if (act_b !== exp_b) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp_b, act_b);
            error_count++;
        end
    endtask

    //--------------------------------------------------
    // Monitor and consumer
    //--------------------------------------------------
    always @(negedge clk) begin : monitor
        ialu_res_s expected;
        if (rst_n) begin
            if (in_credit) begin
                cmd_credits++;
                if (cmd_credits > `IALU_QUEUE_DEPTH) begin
                    $display("%0t: in_credit returned more credits than commands sent", $time);
                    error_count++;
                end
            end
            if (res_valid) begin
                valid_cnt++;
                owed_credits++;
                if (valid_cnt > credit_cnt + `IALU_RES_CREDITS) begin
                    $display("%0t: res_valid issued without a result credit", $time);
                    error_count++;
                end
                if (exp_q.size() == 0) begin
                    $display("%0t: res_valid with no command outstanding", $time);
                    error_count++;
                end else begin
                    expected = exp_q.pop_front();
                    check_res("res.data", expected.data, res.data);
                    check_cmp("res.cmp", expected.cmp, res.cmp);
                end
            end
            if (res_credit) begin
                credit_cnt++;
            end
        end
    end

    // Credits go back after a random delay
    always begin
        @(posedge clk);
        #1;
        res_credit = 1'b0;
        if (rst_n && !hold_credits && owed_credits > 0 && $urandom_range(2, 0) == 0) begin
            res_credit = 1'b1;
            owed_credits--;
        end
    end

    //--------------------------------------------------
    // Driver and tests
    //--------------------------------------------------
    task automatic send_cmd(input ialu_cmd_e cmd);
        ialu_req_s req;
        int        waited;
        req.cmd = cmd;
        for (int i = 0; i < `IALU_LANES; i++) begin
            req.op1[i] = rand_word();
            req.op2[i] = ($urandom_range(3, 0) == 0) ? req.op1[i] : rand_word();
        end
        waited = 0;
        while (cmd_credits == 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (cmd_credits == 0) begin
            $display("%0t: no command credit came back within %0d cycles", $time, TIMEOUT);
            error_count++;
        end else begin
            in_valid = 1'b1;
            in_req   = req;
            cmd_credits--;
            exp_q.push_back(model_result(req));
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || owed_credits != 0) && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0 || owed_credits != 0) begin
            $display("%0t: %0d results still missing after %0d cycles",
                     $time, exp_q.size(), TIMEOUT);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count != errs_before) begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, error_count - errs_before);
        end else begin
            $display("test %s ok", name);
        end
    endtask

    task automatic run_batch(input string name, input ialu_cmd_e lo, input ialu_cmd_e hi,
                             input int n);
        int errs;
        errs = error_count;
        for (int k = 0; k < n; k++) begin
            send_cmd(ialu_cmd_e'($urandom_range(hi, lo)));
        end
        drain();
        report_test(name, errs);
    endtask

    task automatic test_idle();
        int errs;
        errs = error_count;
        repeat (20) begin
            @(negedge clk);
            check_flag("res_valid", 1'b0, res_valid);
            check_flag("in_credit", 1'b0, in_credit);
        end
        @(posedge clk);
        #1;
        report_test("idle_after_reset", errs);
    endtask

    // Consumer withholds credits while the pipeline fills up
    task automatic test_backpressure();
        int errs;
        int seen_before;
        errs         = error_count;
        seen_before  = valid_cnt;
        hold_credits = 1'b1;
        fork
            begin
                for (int k = 0; k < 12; k++) begin
                    send_cmd(ialu_cmd_e'($urandom_range(CMD_MULHU, CMD_AND)));
                end
            end
            begin
                repeat (200) @(posedge clk);
                #3;
                if (valid_cnt - seen_before != `IALU_RES_CREDITS) begin
                    $display("%0t: %0d results left while credits were held",
                             $time, valid_cnt - seen_before);
                    error_count++;
                end
                if (cmd_credits != 0) begin
                    $display("%0t: command queue never filled under back-pressure", $time);
                    error_count++;
                end
                hold_credits = 1'b0;
            end
        join
        drain();
        report_test("backpressure", errs);
    endtask

    initial begin
        void'($urandom(32'h0836644c));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_req       = '0;
        res_credit   = 1'b0;
        cmd_credits  = `IALU_QUEUE_DEPTH;
        owed_credits = 0;
        valid_cnt    = 0;
        credit_cnt   = 0;
        hold_credits = 1'b0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_idle();
        run_batch("logic_add_sub", CMD_AND, CMD_SUB, 80);
        run_batch("compare", CMD_LT, CMD_GEU, 80);
        run_batch("shift", CMD_SLL, CMD_SRA, 60);
        run_batch("multiply", CMD_MUL, CMD_MULHU, 24);
        test_backpressure();
        run_batch("mixed", CMD_AND, CMD_MULHU, 60);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- logic/ialu_decode.sv
// --------------------------------------------------
// Vector ALU decode stage
// Credited command queue feeding a registered
// micro-op decode
// --------------------------------------------------

`include "ialu_defs.svh"

module ialu_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  ialu_pkg::ialu_req_s in_req,
    output logic                in_credit,
    output logic                uop_valid,
    output ialu_pkg::ialu_uop_s uop,
    input  logic                uop_ready
);
    import ialu_pkg::*;

    localparam int PTR_W = $clog2(`IALU_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`IALU_QUEUE_DEPTH + 1);

    ialu_req_s          queue [`IALU_QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               pop;
    ialu_req_s          head;
    ialu_uop_s          dec;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`IALU_QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    //--------------------------------------------------
    // Command queue
    //--------------------------------------------------
    assign head      = queue[rd_ptr];
    assign pop       = (count != '0) && (!uop_valid || uop_ready);
    assign in_credit = pop;                    // One credit back per pop

    always_ff @(posedge clk) begin
        if (in_valid) begin
            queue[wr_ptr] <= in_req;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(in_valid) - CNT_W'(pop);  // Source never overruns
        end
    end

    //--------------------------------------------------
    // Micro-op decode
    //--------------------------------------------------
    always_comb begin
        dec     = '0;
        dec.op1 = head.op1;
        dec.op2 = head.op2;
        case (head.cmd)
            CMD_AND : dec.sel = 3'b010;
            CMD_OR  : dec.sel = 3'b100;
            CMD_XOR : dec.sel = 3'b110;
            CMD_SUB : dec.sub = 1'b1;
            CMD_LT, CMD_GE : begin
                dec.sub = 1'b1;
                dec.sel = {2'b01, head.cmd == CMD_GE};
            end
            CMD_LTU, CMD_GEU : begin
                dec.sub = 1'b1;
                dec.sel = {2'b10, head.cmd == CMD_GEU};
            end
            CMD_EQ, CMD_NE : begin
                dec.sub = 1'b1;
                dec.sel = {2'b11, head.cmd == CMD_NE};
            end
            CMD_SLL : dec.shft = 2'b01;
            CMD_SRL : dec.shft = 2'b10;
            CMD_SRA : dec.shft = 2'b11;
            CMD_MUL, CMD_MULH, CMD_MULHSU, CMD_MULHU : begin
                dec.iter       = 1'b1;
                dec.mul_hi     = (head.cmd != CMD_MUL);
                dec.op1_signed = (head.cmd != CMD_MULHU);
                dec.op2_signed = (head.cmd == CMD_MUL) || (head.cmd == CMD_MULH);
            end
            default : begin                    // ADD and unused codes
            end
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
        end else if (pop) begin
            uop_valid <= 1'b1;
        end else if (uop_ready) begin
            uop_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            uop <= dec;
        end
    end

endmodule

//--- logic/ialu_defs.svh
// --------------------------------------------------
// Vector integer ALU sizing
// Lane count, word width, queue depth and credits
// --------------------------------------------------

`ifndef IALU_DEFS_SVH
`define IALU_DEFS_SVH

`define IALU_LANES        4    // Parallel lanes
`define IALU_XLEN         32   // Operand width
`define IALU_SHAMT_W      5    // Shift amount bits

// Command queue entries, also the initial command credits
`define IALU_QUEUE_DEPTH  4

`define IALU_RES_CREDITS  2    // Result slots at the consumer
`define IALU_CNT_W        5    // Multiply step counter

`endif

//--- logic/ialu_execute.sv
// --------------------------------------------------
// Vector ALU execute stage
// Per-lane adder, shifter, logic and compares plus a
// bit-serial shift-add multiplier
// --------------------------------------------------

`include "ialu_defs.svh"

module ialu_execute (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                uop_valid,
    input  ialu_pkg::ialu_uop_s uop,
    output logic                uop_ready,
    output logic                ex_valid,
    output ialu_pkg::ialu_res_s ex_res,
    input  logic                ex_ready
);
    import ialu_pkg::*;

    logic                   busy;              // Multiply iterating
    logic                   fin;               // Product waits for output slot
    logic [`IALU_CNT_W-1:0] step_cnt;          // Shared by all lanes
    logic                   last_step;
    logic                   mul_hi_q;
    logic                   op1_s_q;
    logic                   op2_s_q;
    logic                   out_free;
    logic                   accept;
    lane_vec_t              alu_word;
    lane_vec_t              mul_word;
    logic [`IALU_LANES-1:0] alu_cmp;

    assign out_free  = !ex_valid || ex_ready;
    assign uop_ready = !busy && !fin && out_free;
    assign accept    = uop_valid && uop_ready;
    assign last_step = (step_cnt == `IALU_CNT_W'(`IALU_XLEN - 1));

    //--------------------------------------------------
    // Multiply sequencing
    //--------------------------------------------------
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            fin      <= 1'b0;
            step_cnt <= '0;
        end else if (accept && uop.iter) begin
            busy     <= 1'b1;
            step_cnt <= '0;
        end else if (busy) begin
            step_cnt <= step_cnt + 1'b1;
            if (last_step) begin
                busy <= 1'b0;
                fin  <= 1'b1;
            end
        end else if (fin && out_free) begin
            fin <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && uop.iter) begin
            mul_hi_q <= uop.mul_hi;
            op1_s_q  <= uop.op1_signed;
            op2_s_q  <= uop.op2_signed;
        end
    end

    //--------------------------------------------------
    // Lanes
    //--------------------------------------------------
    for (genvar i = 0; i < `IALU_LANES; i++) begin : g_lane
        lane_word_t               a;
        lane_word_t               b;
        logic [`IALU_SHAMT_W-1:0] shamt;
        logic [`IALU_XLEN:0]      sum;
        ialu_flags_s              flags;
        lane_word_t               shft_res;
        lane_word_t               logic_res;
        lane_word_t               res_w;
        logic                     cmp_raw;
        logic                     is_cmp;
        lane_word_t               acc_hi;
        lane_word_t               acc_lo;      // Multiplier bits, then product low half
        lane_word_t               mcand;
        logic [`IALU_XLEN:0]      acc_ext;
        logic [`IALU_XLEN:0]      addend;
        logic [`IALU_XLEN:0]      partial;

        assign a     = uop.op1[i];
        assign b     = uop.op2[i];
        assign shamt = b[`IALU_SHAMT_W-1:0];
        assign sum   = uop.sub ? ({1'b0, a} - {1'b0, b}) : ({1'b0, a} + {1'b0, b});

        always_comb begin
            flags.c = sum[`IALU_XLEN];
            flags.z = ~|sum[`IALU_XLEN-1:0];
            flags.s = sum[`IALU_XLEN-1];
            flags.o = (~a[`IALU_XLEN-1] &  b[`IALU_XLEN-1] &  sum[`IALU_XLEN-1]) |
                      ( a[`IALU_XLEN-1] & ~b[`IALU_XLEN-1] & ~sum[`IALU_XLEN-1]);
        end

        always_comb begin
            case (uop.shft)
                2'b10   : shft_res = a >> shamt;
                2'b11   : shft_res = $signed(a) >>> shamt;
                default : shft_res = a << shamt;
            endcase
        end

        always_comb begin
            case (uop.sel[2:1])
                2'b01   : logic_res = a & b;
                2'b10   : logic_res = a | b;
                default : logic_res = a ^ b;
            endcase
        end

        always_comb begin
            case (uop.sel[2:1])
                2'b01   : cmp_raw = flags.s ^ flags.o;   // Signed less than
                2'b10   : cmp_raw = flags.c;             // Unsigned less than
                default : cmp_raw = flags.z;
            endcase
        end

        assign is_cmp     = uop.sub && (uop.sel != 3'b000);
        assign alu_cmp[i] = is_cmp && (cmp_raw ^ uop.sel[0]);

        always_comb begin
            if (uop.shft != 2'b00) begin
                res_w = shft_res;
            end else if (uop.sel == 3'b000) begin
                res_w = sum[`IALU_XLEN-1:0];
            end else if (uop.sub) begin
                res_w = lane_word_t'(alu_cmp[i]);
            end else begin
                res_w = logic_res;
            end
        end

        assign alu_word[i] = res_w;

        // One multiplier bit per step, last step negates for a signed op2
        assign acc_ext = {op1_s_q & acc_hi[`IALU_XLEN-1], acc_hi};
        assign addend  = acc_lo[0] ? {op1_s_q & mcand[`IALU_XLEN-1], mcand} : '0;
        assign partial = (op2_s_q && last_step) ? (acc_ext - addend) : (acc_ext + addend);

        always_ff @(posedge clk) begin
            if (accept && uop.iter) begin
                acc_hi <= '0;
                acc_lo <= b;
                mcand  <= a;
            end else if (busy) begin
                {acc_hi, acc_lo} <= {partial, acc_lo[`IALU_XLEN-1:1]};
            end
        end

        assign mul_word[i] = mul_hi_q ? acc_hi : acc_lo;
    end

    //--------------------------------------------------
    // Output register
    //--------------------------------------------------
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if ((accept && !uop.iter) || (fin && out_free)) begin
            ex_valid <= 1'b1;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !uop.iter) begin
            ex_res.data <= alu_word;
            ex_res.cmp  <= alu_cmp;
        end else if (fin && out_free) begin
            ex_res.data <= mul_word;
            ex_res.cmp  <= '0;                 // Multiplies never compare
        end
    end

endmodule

//--- logic/ialu_pkg.sv
// --------------------------------------------------
// Vector integer ALU types
// Command encoding and the structs passed between
// the decode, execute and result stages
// --------------------------------------------------

`include "ialu_defs.svh"

package ialu_pkg;

    typedef enum logic [4:0] {
        CMD_AND,
        CMD_OR,
        CMD_XOR,
        CMD_ADD,
        CMD_SUB,
        CMD_LT,
        CMD_LTU,
        CMD_EQ,
        CMD_NE,
        CMD_GE,
        CMD_GEU,
        CMD_SLL,
        CMD_SRL,
        CMD_SRA,
        CMD_MUL,
        CMD_MULH,
        CMD_MULHSU,
        CMD_MULHU
    } ialu_cmd_e;

    typedef logic [`IALU_XLEN-1:0] lane_word_t;
    typedef lane_word_t [`IALU_LANES-1:0] lane_vec_t;

    typedef struct packed {
        ialu_cmd_e  cmd;
        lane_vec_t  op1;
        lane_vec_t  op2;
    } ialu_req_s;

    typedef struct packed {
        logic       z;          // Zero
        logic       s;          // Sign
        logic       o;          // Overflow
        logic       c;          // Carry out, borrow on subtract
    } ialu_flags_s;

    // sel with sub clear: 000 sum, 01x AND, 10x OR, 11x XOR
    // sel with sub set:   000 sum, {01 LT, 10 LTU, 11 EQ} with bit 0 inverting
    typedef struct packed {
        logic       sub;        // Adder subtracts
        logic [1:0] shft;       // 01 SLL, 10 SRL, 11 SRA
        logic [2:0] sel;        // Logic or compare select
        logic       iter;       // Iterative multiply
        logic       mul_hi;     // Upper product half wanted
        logic       op1_signed;
        logic       op2_signed;
        lane_vec_t  op1;
        lane_vec_t  op2;
    } ialu_uop_s;

    typedef struct packed {
        lane_vec_t              data;
        logic [`IALU_LANES-1:0] cmp;   // Compare outcome per lane
    } ialu_res_s;

endpackage

//--- logic/ialu_result.sv
// --------------------------------------------------
// Vector ALU result stage
// Holds one result and issues it against consumer
// credits
// --------------------------------------------------

`include "ialu_defs.svh"

module ialu_result (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ex_valid,
    input  ialu_pkg::ialu_res_s ex_res,
    output logic                ex_ready,
    output logic                res_valid,
    output ialu_pkg::ialu_res_s res,
    input  logic                res_credit
);

    localparam int CRED_W = $clog2(`IALU_RES_CREDITS + 1);

    logic              full;                   // Result register occupied
    logic [CRED_W-1:0] credits;
    logic              take;

    assign res_valid = full && (credits != '0);
    assign ex_ready  = !full || res_valid;
    assign take      = ex_valid && ex_ready;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (take) begin
            full <= 1'b1;
        end else if (res_valid) begin
            full <= 1'b0;
        end
    end

    //--------------------------------------------------
    // Consumer credits
    //--------------------------------------------------
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            credits <= CRED_W'(`IALU_RES_CREDITS);
        end else begin
            credits <= credits - CRED_W'(res_valid) + CRED_W'(res_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res <= ex_res;
        end
    end

endmodule

//--- logic/vec_ialu.sv
// --------------------------------------------------
// Four-lane vector integer ALU
// Decode, execute and result stages with credit
// flow control on both sides
// --------------------------------------------------

module vec_ialu (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  ialu_pkg::ialu_req_s in_req,
    output logic                in_credit,
    output logic                res_valid,
    output ialu_pkg::ialu_res_s res,
    input  logic                res_credit
);
    import ialu_pkg::*;

    logic       uop_valid;
    logic       uop_ready;
    ialu_uop_s  uop;
    logic       ex_valid;
    logic       ex_ready;
    ialu_res_s  ex_res;

    ialu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .in_credit (in_credit),
        .uop_valid (uop_valid),
        .uop       (uop),
        .uop_ready (uop_ready)
    );

    ialu_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop_valid (uop_valid),
        .uop       (uop),
        .uop_ready (uop_ready),
        .ex_valid  (ex_valid),
        .ex_res    (ex_res),
        .ex_ready  (ex_ready)
    );

    ialu_result u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .ex_res     (ex_res),
        .ex_ready   (ex_ready),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

endmodule

//--- vec_ialu.f
+incdir+logic
logic/ialu_pkg.sv
logic/ialu_decode.sv
logic/ialu_execute.sv
logic/ialu_result.sv
logic/vec_ialu.sv
bench/vec_ialu_props.sv
bench/vec_ialu_tb.sv
